//--- include/ising_consts.svh
// Ising core sizes
// shared by the package and every RTL block
`ifndef ISING_CONSTS_SVH
`define ISING_CONSTS_SVH

// spin count and element widths
`define ISING_NUM_SPIN      8
`define ISING_BITJ          4
`define ISING_BITH          4
`define ISING_SCALING_BIT   4

// J rows carried by one memory word
`define ISING_PARALLELISM   2

// worst case |E| is 1472
`define ISING_ENERGY_BIT    16

`define ISING_FLIP_ADDR_BIT 4
`define ISING_J_ADDR_BIT    2

`endif

//--- rtl/ising_pkg.sv
// Ising core types
// spin bit i is +1 when set, element i of a vector sits at bits i*W +: W
`default_nettype none
`include "ising_consts.svh"

package ising_pkg;

    typedef logic [`ISING_NUM_SPIN-1:0] spin_t;
    typedef logic signed [`ISING_ENERGY_BIT-1:0] energy_t;

    // row p of a word at p*NUM_SPIN*BITJ, element j of a row at j*BITJ
    typedef logic [`ISING_PARALLELISM*`ISING_NUM_SPIN*`ISING_BITJ-1:0] j_block_t;

    typedef logic [`ISING_J_ADDR_BIT-1:0] j_addr_t;
    typedef logic [`ISING_FLIP_ADDR_BIT-1:0] flip_addr_t;
    typedef logic [`ISING_NUM_SPIN*`ISING_BITH-1:0] hbias_t;

    typedef enum logic [1:0] {
        IDLE,
        EVAL,
        WAIT,
        NEXT_FLIP
    } fm_state_t;

endpackage

`default_nettype wire

//--- rtl/ising_if.sv
// Ising core buses
// J row stream into the energy monitor, spin/energy exchange with the flip manager
`timescale 1ns/1ps
`default_nettype none

interface weight_stream_if import ising_pkg::*; ();
    logic     valid;
    logic     ready;
    logic     last;
    j_block_t data;

    modport source (
        output valid, data, last,
        input  ready
    );

    modport sink (
        input  valid, data, last,
        output ready
    );
endinterface

interface energy_if import ising_pkg::*; ();
    // request side
    logic    spin_valid;
    logic    spin_ready;
    spin_t   spin;
    // result side
    logic    energy_valid;
    logic    energy_ready;
    energy_t energy;

    modport manager (
        output spin_valid, spin, energy_ready,
        input  spin_ready, energy_valid, energy
    );

    modport monitor (
        input  spin_valid, spin, energy_ready,
        output spin_ready, energy_valid, energy
    );
endinterface

`default_nettype wire

//--- rtl/weight_fetch.sv
// weight fetcher
// reads one pass of J row blocks and offers them as a valid/ready stream
`timescale 1ns/1ps
`default_nettype none
`include "ising_consts.svh"

module weight_fetch import ising_pkg::*; (
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic            start_i,
    output logic            j_ren_o,
    output j_addr_t         j_raddr_o,
    input  j_block_t        j_rdata_i,
    weight_stream_if.source weight_o
);
    localparam j_addr_t last_word = j_addr_t'(`ISING_NUM_SPIN / `ISING_PARALLELISM - 1);

    logic       busy_q;
    j_addr_t    addr_q;
    logic       at_last;
    logic       room;
    logic       rvalid_q;
    logic       rlast_q;
    logic [1:0] fifo_cnt_q;
    logic       wr_ptr_q;
    logic       rd_ptr_q;
    logic       push;
    logic       pop;
    j_block_t   data_mem [2];
    logic       last_mem [2];

    assign at_last = (addr_q == last_word);
    // a read still in flight already owns a slot
    assign room = (fifo_cnt_q + {1'b0, rvalid_q}) < 2'd2;
    assign j_ren_o = (start_i | busy_q) & room;
    assign j_raddr_o = addr_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q <= 1'b0;
            addr_q <= '0;
            rvalid_q <= 1'b0;
            rlast_q <= 1'b0;
        end else begin
            rvalid_q <= j_ren_o;
            rlast_q <= j_ren_o & at_last;
            if (j_ren_o) begin
                addr_q <= at_last ? '0 : addr_q + 1'b1;
                busy_q <= ~at_last;
            end else if (start_i) begin
                busy_q <= 1'b1;
            end
        end
    end

    // two-entry buffer
    assign push = rvalid_q;
    assign pop = weight_o.valid & weight_o.ready;
    assign weight_o.valid = (fifo_cnt_q != 2'd0);
    assign weight_o.data = data_mem[rd_ptr_q];
    assign weight_o.last = last_mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push) begin
            data_mem[wr_ptr_q] <= j_rdata_i;
            last_mem[wr_ptr_q] <= rlast_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            fifo_cnt_q <= 2'd0;
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
        end else begin
            if (push) wr_ptr_q <= ~wr_ptr_q;
            if (pop) rd_ptr_q <= ~rd_ptr_q;
            case ({push, pop})
                2'b10: fifo_cnt_q <= fifo_cnt_q + 2'd1;
                2'b01: fifo_cnt_q <= fifo_cnt_q - 2'd1;
                default: fifo_cnt_q <= fifo_cnt_q;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/energy_monitor.sv
// energy monitor
// sums s_i * (h_i * hscaling + sum_j J_ij * s_j) over the J stream for one spin vector
`timescale 1ns/1ps
`default_nettype none
`include "ising_consts.svh"

module energy_monitor import ising_pkg::*; (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  hbias_t                        h_bias_i,
    input  logic [`ISING_SCALING_BIT-1:0] hscaling_i,
    weight_stream_if.sink                 weight_i,
    energy_if.monitor                     energy_io,
    output logic                          start_o
);
    localparam int row_bits = `ISING_NUM_SPIN * `ISING_BITJ;

    logic    busy_q;
    logic    result_q;
    spin_t   spin_q;
    j_addr_t blk_q;
    energy_t acc_q;
    energy_t beat_sum;
    logic    spin_hs;
    logic    beat_hs;
    logic    result_hs;

    assign energy_io.spin_ready = ~busy_q & ~result_q;
    assign spin_hs = energy_io.spin_valid & energy_io.spin_ready;
    assign start_o = spin_hs;

    // no beats taken while a result waits
    assign weight_i.ready = busy_q;
    assign beat_hs = weight_i.valid & weight_i.ready;

    assign energy_io.energy_valid = result_q;
    assign energy_io.energy = acc_q;
    assign result_hs = energy_io.energy_valid & energy_io.energy_ready;

    // contribution of the PARALLELISM rows in this beat
    always_comb begin
        int row;
        logic signed [`ISING_BITH-1:0] h_elem;
        logic signed [`ISING_BITJ-1:0] j_elem;
        energy_t local_field;
        beat_sum = '0;
        for (int p = 0; p < `ISING_PARALLELISM; p++) begin
            row = int'(blk_q) * `ISING_PARALLELISM + p;
            h_elem = h_bias_i[row * `ISING_BITH +: `ISING_BITH];
            local_field = energy_t'(h_elem) * energy_t'(hscaling_i);
            for (int j = 0; j < `ISING_NUM_SPIN; j++) begin
                j_elem = weight_i.data[p * row_bits + j * `ISING_BITJ +: `ISING_BITJ];
                if (spin_q[j]) begin
                    local_field = local_field + energy_t'(j_elem);
                end else begin
                    local_field = local_field - energy_t'(j_elem);
                end
            end
            if (spin_q[row]) begin
                beat_sum = beat_sum + local_field;
            end else begin
                beat_sum = beat_sum - local_field;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q <= 1'b0;
            result_q <= 1'b0;
        end else begin
            if (spin_hs) begin
                busy_q <= 1'b1;
            end else if (beat_hs && weight_i.last) begin
                busy_q <= 1'b0;
            end
            if (beat_hs && weight_i.last) begin
                result_q <= 1'b1;
            end else if (result_hs) begin
                result_q <= 1'b0;
            end
        end
    end

    // accumulator doubles as the result register
    always_ff @(posedge clk_i) begin
        if (spin_hs) begin
            spin_q <= energy_io.spin;
            blk_q <= '0;
            acc_q <= '0;
        end else if (beat_hs) begin
            acc_q <= acc_q + beat_sum;
            blk_q <= blk_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/flip_manager.sv
// flip manager
// annealing loop over the flip memory, keeps the best spin vector and its energy
`timescale 1ns/1ps
`default_nettype none

module flip_manager import ising_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       config_valid_i,
    input  spin_t      config_spin_i,
    input  logic       cmpt_en_i,
    input  logic       en_comparison_i,
    input  flip_addr_t flip_num_i,
    output logic       flip_ren_o,
    output flip_addr_t flip_raddr_o,
    input  spin_t      flip_rdata_i,
    energy_if.manager  energy_io,
    output logic       cmpt_idle_o,
    output logic       energy_update_o,
    output energy_t    best_energy_o,
    output spin_t      best_spin_o
);
    fm_state_t  state_q;
    fm_state_t  state_d;
    logic       cmpt_en_q;
    logic       start;
    spin_t      cfg_spin_q;
    spin_t      cand_q;
    flip_addr_t flip_idx_q;
    flip_addr_t flip_num_q;
    logic       first_q;
    logic       update_q;
    energy_t    best_energy_q;
    spin_t      best_spin_q;
    logic       spin_hs;
    logic       energy_hs;
    logic       accept;
    logic       more_flips;

    assign start = cmpt_en_i & ~cmpt_en_q;
    assign spin_hs = energy_io.spin_valid & energy_io.spin_ready;
    assign energy_hs = energy_io.energy_valid & energy_io.energy_ready;
    // initial spin always taken, later ones only if strictly lower
    assign accept = first_q | ~en_comparison_i | (energy_io.energy < best_energy_q);
    assign more_flips = (flip_idx_q != flip_num_q);

    assign energy_io.spin_valid = (state_q == EVAL);
    assign energy_io.spin = cand_q;
    assign energy_io.energy_ready = (state_q == WAIT);

    // read goes out with the result, pattern is back in NEXT_FLIP
    assign flip_ren_o = energy_hs & more_flips;
    assign flip_raddr_o = flip_idx_q;

    assign cmpt_idle_o = (state_q == IDLE);
    assign energy_update_o = update_q;
    assign best_energy_o = best_energy_q;
    assign best_spin_o = best_spin_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: if (start) state_d = EVAL;
            EVAL: if (spin_hs) state_d = WAIT;
            WAIT: if (energy_hs) state_d = more_flips ? NEXT_FLIP : IDLE;
            NEXT_FLIP: state_d = EVAL;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
            cmpt_en_q <= 1'b0;
            first_q <= 1'b0;
            update_q <= 1'b0;
            flip_idx_q <= '0;
            flip_num_q <= '0;
        end else begin
            state_q <= state_d;
            cmpt_en_q <= cmpt_en_i;
            update_q <= energy_hs & accept;
            if (state_q == IDLE && start) begin
                first_q <= 1'b1;
                flip_idx_q <= '0;
                flip_num_q <= flip_num_i;
            end else if (energy_hs) begin
                first_q <= 1'b0;
            end
            if (state_q == NEXT_FLIP) flip_idx_q <= flip_idx_q + 1'b1;
        end
    end

    // candidate is built from the last accepted spin
    always_ff @(posedge clk_i) begin
        if (config_valid_i) cfg_spin_q <= config_spin_i;
        if (state_q == IDLE && start) begin
            cand_q <= cfg_spin_q;
        end else if (state_q == NEXT_FLIP) begin
            cand_q <= best_spin_q ^ flip_rdata_i;
        end
        if (energy_hs && accept) begin
            best_energy_q <= energy_io.energy;
            best_spin_q <= cand_q;
        end
    end

endmodule

`default_nettype wire

//--- rtl/ising_digital_macro.sv
// digital Ising macro
// weight fetcher, energy monitor and flip manager around the J and flip memories
`timescale 1ns/1ps
`default_nettype none
`include "ising_consts.svh"

module ising_digital_macro import ising_pkg::*; (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          config_valid_i,
    input  spin_t                         config_spin_i,
    input  logic                          cmpt_en_i,
    input  logic                          en_comparison_i,
    input  flip_addr_t                    flip_num_i,
    input  logic [`ISING_SCALING_BIT-1:0] hscaling_i,
    input  hbias_t                        h_bias_i,
    output logic                          j_ren_o,
    output j_addr_t                       j_raddr_o,
    input  j_block_t                      j_rdata_i,
    output logic                          flip_ren_o,
    output flip_addr_t                    flip_raddr_o,
    input  spin_t                         flip_rdata_i,
    output logic                          cmpt_idle_o,
    output logic                          energy_update_o,
    output energy_t                       best_energy_o,
    output spin_t                         best_spin_o
);
    logic pass_start;

    weight_stream_if weight_bus ();
    energy_if        energy_bus ();

    weight_fetch u_weight_fetch (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .start_i   (pass_start),
        .j_ren_o   (j_ren_o),
        .j_raddr_o (j_raddr_o),
        .j_rdata_i (j_rdata_i),
        .weight_o  (weight_bus)
    );

    energy_monitor u_energy_monitor (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .h_bias_i   (h_bias_i),
        .hscaling_i (hscaling_i),
        .weight_i   (weight_bus),
        .energy_io  (energy_bus),
        .start_o    (pass_start)
    );

    flip_manager u_flip_manager (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .config_valid_i  (config_valid_i),
        .config_spin_i   (config_spin_i),
        .cmpt_en_i       (cmpt_en_i),
        .en_comparison_i (en_comparison_i),
        .flip_num_i      (flip_num_i),
        .flip_ren_o      (flip_ren_o),
        .flip_raddr_o    (flip_raddr_o),
        .flip_rdata_i    (flip_rdata_i),
        .energy_io       (energy_bus),
        .cmpt_idle_o     (cmpt_idle_o),
        .energy_update_o (energy_update_o),
        .best_energy_o   (best_energy_o),
        .best_spin_o     (best_spin_o)
    );

endmodule

`default_nettype wire

//--- testbench/tb_ising_digital_macro.sv
// testbench for the digital Ising macro
// random J, h and flip patterns, table of annealing runs checked against an energy model
`timescale 1ns/1ps
`default_nettype none
`include "ising_consts.svh"

module tb_ising_digital_macro import ising_pkg::*; ();
    localparam int n_spin = `ISING_NUM_SPIN;
    localparam int n_par = `ISING_PARALLELISM;
    localparam int n_words = `ISING_NUM_SPIN / `ISING_PARALLELISM;
    localparam int n_flip = 1 << `ISING_FLIP_ADDR_BIT;
    localparam int n_rows = 7;
    localparam int timeout_cycles = 2000;

    typedef struct {
        spin_t                         spin;
        logic [`ISING_SCALING_BIT-1:0] hscale;
        flip_addr_t                    flips;
        logic                          cmp;
        energy_t                       exp_energy;
        spin_t                         exp_spin;
        int                            exp_updates;
    } run_row_t;

    logic                          clk_i;
    logic                          reset_i;
    logic                          config_valid_i;
    spin_t                         config_spin_i;
    logic                          cmpt_en_i;
    logic                          en_comparison_i;
    flip_addr_t                    flip_num_i;
    logic [`ISING_SCALING_BIT-1:0] hscaling_i;
    hbias_t                        h_bias_i;
    logic                          j_ren_o;
    j_addr_t                       j_raddr_o;
    j_block_t                      j_rdata_i;
    logic                          flip_ren_o;
    flip_addr_t                    flip_raddr_o;
    spin_t                         flip_rdata_i;
    logic                          cmpt_idle_o;
    logic                          energy_update_o;
    energy_t                       best_energy_o;
    spin_t                         best_spin_o;

    logic [31:0] lfsr_q;
    int          j_val [n_spin][n_spin];
    int          h_val [n_spin];
    j_block_t    j_mem [n_words];
    spin_t       flip_mem [n_flip];
    run_row_t    table_q [n_rows];

    ising_digital_macro DUT (.*);

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    // J and flip memories, one cycle read latency
    always @(posedge clk_i) begin
        if (j_ren_o) j_rdata_i <= j_mem[j_raddr_o];
        if (flip_ren_o) flip_rdata_i <= flip_mem[flip_raddr_o];
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) return (s >> 1) ^ 32'h80200003;
        return s >> 1;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r[b] = lfsr_q[0];
        end
        return r;
    endfunction

    task automatic build_model();
        logic [31:0] r;
        for (int i = 0; i < n_spin; i++) begin
            for (int j = 0; j < n_spin; j++) begin
                r = take_bits(`ISING_BITJ);
                j_val[i][j] = $signed(r[`ISING_BITJ-1:0]);
                j_mem[i / n_par][((i % n_par) * n_spin + j) * `ISING_BITJ +: `ISING_BITJ] =
                    r[`ISING_BITJ-1:0];
            end
        end
        for (int i = 0; i < n_spin; i++) begin
            r = take_bits(`ISING_BITH);
            h_val[i] = $signed(r[`ISING_BITH-1:0]);
            h_bias_i[i * `ISING_BITH +: `ISING_BITH] = r[`ISING_BITH-1:0];
        end
        for (int f = 0; f < n_flip; f++) begin
            r = take_bits(n_spin);
            flip_mem[f] = r[n_spin-1:0];
        end
    endtask

    // E = sum_i s_i * (h_i * hscaling + sum_j J_ij * s_j)
    function automatic int model_energy(input spin_t s, input int hscale);
        int e;
        int field;
        e = 0;
        for (int i = 0; i < n_spin; i++) begin
            field = h_val[i] * hscale;
            for (int j = 0; j < n_spin; j++) begin
                field = field + (s[j] ? j_val[i][j] : -j_val[i][j]);
            end
            e = e + (s[i] ? field : -field);
        end
        return e;
    endfunction

    task automatic add_row(input int k, input spin_t spin, input int hscale,
                           input int flips, input logic cmp);
        table_q[k].spin = spin;
        table_q[k].hscale = hscale[`ISING_SCALING_BIT-1:0];
        table_q[k].flips = flips[`ISING_FLIP_ADDR_BIT-1:0];
        table_q[k].cmp = cmp;
    endtask

    // greedy descent over the flip patterns, or plain walk with comparison off
    task automatic predict_row(input int k);
        spin_t best;
        spin_t cand;
        int    best_e;
        int    cand_e;
        int    updates;
        best = table_q[k].spin;
        best_e = model_energy(best, int'(table_q[k].hscale));
        updates = 1;
        for (int f = 0; f < int'(table_q[k].flips); f++) begin
            cand = best ^ flip_mem[f];
            cand_e = model_energy(cand, int'(table_q[k].hscale));
            if (!table_q[k].cmp || cand_e < best_e) begin
                best = cand;
                best_e = cand_e;
                updates++;
            end
        end
        table_q[k].exp_energy = energy_t'(best_e);
        table_q[k].exp_spin = best;
        table_q[k].exp_updates = updates;
    endtask

    task automatic stop_run();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_energy(input string name, input energy_t got, input energy_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_spin(input string name, input spin_t got, input spin_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic wait_busy();
        int cycles;
        cycles = 0;
        while (cmpt_idle_o) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > timeout_cycles) begin
                $display("timeout: cmpt_idle_o never dropped after the cmpt_en_i pulse");
                stop_run();
            end
        end
    endtask

    // update pulse and idle rise share the last cycle of a run
    task automatic count_updates(output int updates);
        int cycles;
        updates = 0;
        cycles = 0;
        forever begin
            if (energy_update_o) updates++;
            if (cmpt_idle_o) break;
            @(negedge clk_i);
            cycles++;
            if (cycles > timeout_cycles) begin
                $display("timeout: run did not return to idle");
                stop_run();
            end
        end
    endtask

    task automatic apply_row(input int k);
        int updates;
        @(posedge clk_i);
        config_valid_i <= 1'b1;
        config_spin_i <= table_q[k].spin;
        hscaling_i <= table_q[k].hscale;
        flip_num_i <= table_q[k].flips;
        en_comparison_i <= table_q[k].cmp;
        @(posedge clk_i);
        config_valid_i <= 1'b0;
        cmpt_en_i <= 1'b1;
        @(posedge clk_i);
        cmpt_en_i <= 1'b0;
        @(negedge clk_i);
        wait_busy();
        count_updates(updates);
        check_count("energy_update_o pulses", updates, table_q[k].exp_updates);
        check_energy("best_energy_o", best_energy_o, table_q[k].exp_energy);
        check_spin("best_spin_o", best_spin_o, table_q[k].exp_spin);
    endtask

    initial begin
        reset_i = 1'b1;
        config_valid_i = 1'b0;
        config_spin_i = '0;
        cmpt_en_i = 1'b0;
        en_comparison_i = 1'b0;
        flip_num_i = '0;
        hscaling_i = '0;
        h_bias_i = '0;
        j_rdata_i = '0;
        flip_rdata_i = '0;
        lfsr_q = 32'h1919e5cc;
        build_model();

        // spin, hscaling, flips, comparison
        add_row(0, 8'hA5, 3, 0, 1'b0);
        add_row(1, 8'h3C, 11, 0, 1'b1);
        add_row(2, 8'h0F, 1, 5, 1'b0);
        add_row(3, 8'hF0, 15, 6, 1'b1);
        add_row(4, 8'h5A, 9, 12, 1'b1);
        add_row(5, 8'hC3, 0, 15, 1'b1);
        add_row(6, 8'h96, 6, 9, 1'b0);
        for (int k = 0; k < n_rows; k++) predict_row(k);

        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        check_flag("cmpt_idle_o", cmpt_idle_o, 1'b1);
        check_flag("j_ren_o", j_ren_o, 1'b0);
        check_flag("flip_ren_o", flip_ren_o, 1'b0);
        check_flag("energy_update_o", energy_update_o, 1'b0);

        // rows run back to back with no reset in between
        for (int k = 0; k < n_rows; k++) apply_row(k);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- ising_digital_macro.f
+incdir+include
rtl/ising_pkg.sv
rtl/ising_if.sv
rtl/weight_fetch.sv
rtl/energy_monitor.sv
rtl/flip_manager.sv
rtl/ising_digital_macro.sv
testbench/tb_ising_digital_macro.sv

//--- Makefile
# Verilator build and run for the digital Ising macro testbench

VERILATOR ?= verilator
TOP       ?= tb_ising_digital_macro
FILELIST  ?= ising_digital_macro.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0 --Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST)) include/ising_consts.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
